// ==== src/rv32_mem_pkg.sv ====
package rv32_mem_pkg;

  // Data and address width of the core
  localparam int XLEN = 32;
  // Word address on the bus covers byte address bits 31..2
  localparam int WB_ADR_W = 30;
  // One select bit per byte lane
  localparam int SEL_W = 4;
  // SRAM depth in words, anything at or above is out of range
  localparam int SRAM_WORDS = 1024;
  localparam int SRAM_AW = $clog2(SRAM_WORDS);

  typedef enum logic [1:0] {
    MEM_BYTE = 2'd0,
    MEM_HALF = 2'd1,
    MEM_WORD = 2'd2
  } mem_size_t;

  // Byte enables for a size at a given offset within the word
  function automatic logic [SEL_W-1:0] lane_sel(mem_size_t size, logic [1:0] off);
    case (size)
      MEM_BYTE: return SEL_W'(1) << off;
      MEM_HALF: return off[1] ? 4'b1100 : 4'b0011;
      default:  return 4'b1111;
    endcase
  endfunction

  // Half must sit on an even byte, word on a word boundary
  function automatic logic is_misaligned(mem_size_t size, logic [1:0] off);
    return ((size == MEM_HALF) && off[0]) || ((size == MEM_WORD) && (off != 2'b00));
  endfunction

  // Move the addressed lane down to bit 0, then sign or zero extend
  function automatic logic [XLEN-1:0] load_extend(logic [XLEN-1:0] word, logic [1:0] off,
                                                  mem_size_t size, logic is_unsigned);
    logic [XLEN-1:0] shifted;
    shifted = word >> {off, 3'b000};
    case (size)
      MEM_BYTE: return is_unsigned ? {{(XLEN-8){1'b0}}, shifted[7:0]}
                                   : {{(XLEN-8){shifted[7]}}, shifted[7:0]};
      MEM_HALF: return is_unsigned ? {{(XLEN-16){1'b0}}, shifted[15:0]}
                                   : {{(XLEN-16){shifted[15]}}, shifted[15:0]};
      default:  return shifted;
    endcase
  endfunction

endpackage

// ==== src/wb_if.sv ====
interface wb_if;
  import rv32_mem_pkg::*;

  // Cycle framing, cyc follows stb on this bus
  logic                cyc;
  logic                stb;
  logic                we;
  logic [SEL_W-1:0]    sel;
  logic [WB_ADR_W-1:0] adr;
  logic [XLEN-1:0]     dat_w;
  // Slave response
  logic [XLEN-1:0]     dat_r;
  logic                ack;
  logic                err;
  // Four-phase request and grant toward the arbiter
  logic                bus_req;
  logic                bus_gnt;

  modport master (
    output cyc, stb, we, sel, adr, dat_w, bus_req,
    input  dat_r, ack, err, bus_gnt
  );

  modport slave (
    input  cyc, stb, we, sel, adr, dat_w, bus_req,
    output dat_r, ack, err, bus_gnt
  );

endinterface

// ==== src/lsu_wb_master.sv ====
module lsu_wb_master (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  input  logic                          req_i,
  input  logic                          we_i,
  input  logic                          unsigned_i,
  input  rv32_mem_pkg::mem_size_t       size_i,
  input  logic [rv32_mem_pkg::XLEN-1:0] addr_i,
  input  logic [rv32_mem_pkg::XLEN-1:0] wdata_i,
  output logic                          ack_o,
  output logic                          err_o,
  output logic [rv32_mem_pkg::XLEN-1:0] rdata_o,
  wb_if.master                          bus
);
  import rv32_mem_pkg::*;

  typedef enum logic [2:0] {
    IDLE,
    REQ,
    CYCLE,
    DONE,
    RELEASE
  } lsu_state_t;

  lsu_state_t state_q;

  // Operands captured when the core request is accepted
  logic [XLEN-1:0] addr_q;
  logic [XLEN-1:0] wdata_q;
  mem_size_t       size_q;
  logic            we_q;
  logic            uns_q;
  logic            mis_q;

  // Single master view, cycle framing is just the strobe
  assign bus.cyc = bus.stb;

  // Control path
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q     <= IDLE;
      bus.bus_req <= 1'b0;
      bus.stb     <= 1'b0;
      bus.we      <= 1'b0;
      ack_o       <= 1'b0;
      err_o       <= 1'b0;
    end else begin
      case (state_q)
        IDLE: begin
          // Previous result no longer needed once a new access starts
          if (req_i) begin
            err_o   <= 1'b0;
            state_q <= REQ;
          end
        end
        REQ: begin
          if (!bus.bus_req) begin
            // Alignment is known here, bad accesses never reach the bus
            if (mis_q) begin
              ack_o   <= 1'b1;
              err_o   <= 1'b1;
              state_q <= DONE;
            end else begin
              bus.bus_req <= 1'b1;
            end
          end else if (bus.bus_gnt) begin
            bus.stb <= 1'b1;
            bus.we  <= we_q;
            state_q <= CYCLE;
          end
        end
        CYCLE: begin
          // Either response ends the cycle and the bus request
          if (bus.ack || bus.err) begin
            bus.stb     <= 1'b0;
            bus.we      <= 1'b0;
            bus.bus_req <= 1'b0;
            ack_o       <= 1'b1;
            err_o       <= bus.err;
            state_q     <= DONE;
          end
        end
        DONE: begin
          // Hold the result until the core drops its request
          if (!req_i) begin
            ack_o   <= 1'b0;
            state_q <= RELEASE;
          end
        end
        RELEASE: begin
          // Arbiter closes its half of the handshake
          if (!bus.bus_gnt) begin
            state_q <= IDLE;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // Operand, bus payload and load data registers
  always_ff @(posedge clk_i) begin
    if (state_q == IDLE && req_i) begin
      addr_q  <= addr_i;
      wdata_q <= wdata_i;
      size_q  <= size_i;
      we_q    <= we_i;
      uns_q   <= unsigned_i;
      mis_q   <= is_misaligned(size_i, addr_i[1:0]);
    end
    if (state_q == REQ && bus.bus_req && bus.bus_gnt) begin
      bus.adr   <= addr_q[XLEN-1:2];
      bus.sel   <= lane_sel(size_q, addr_q[1:0]);
      // Store data moves up onto the lanes it is written through
      bus.dat_w <= wdata_q << {addr_q[1:0], 3'b000};
    end
    if (state_q == CYCLE && bus.ack) begin
      rdata_o <= load_extend(bus.dat_r, addr_q[1:0], size_q, uns_q);
    end
  end

  // Strobe only while this master owns the bus
  a_stb_granted: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    bus.stb |-> bus.bus_gnt);

  a_sel_nonzero: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    bus.stb |-> (bus.sel != '0));

  // No completion without a pending core request
  a_ack_needs_req: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (!req_i && !ack_o) |=> !ack_o);

endmodule

// ==== src/wb_arbiter.sv ====
module wb_arbiter (
  input  logic clk_i,
  input  logic rst_n_i,
  wb_if.slave  m0,
  wb_if.slave  m1,
  wb_if.master s
);

  typedef enum logic [1:0] {
    OWN_NONE,
    OWN_M0,
    OWN_M1
  } owner_t;

  owner_t owner_q;

  // Fixed priority on m0, grant held until the owner lets go
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      owner_q <= OWN_NONE;
    end else begin
      case (owner_q)
        OWN_NONE: begin
          if (m0.bus_req) begin
            owner_q <= OWN_M0;
          end else if (m1.bus_req) begin
            owner_q <= OWN_M1;
          end
        end
        OWN_M0: if (!m0.bus_req) owner_q <= OWN_NONE;
        OWN_M1: if (!m1.bus_req) owner_q <= OWN_NONE;
        default: owner_q <= OWN_NONE;
      endcase
    end
  end

  assign m0.bus_gnt = (owner_q == OWN_M0);
  assign m1.bus_gnt = (owner_q == OWN_M1);

  // Forward path, only the owner reaches the slave
  always_comb begin
    s.cyc   = 1'b0;
    s.stb   = 1'b0;
    s.we    = 1'b0;
    s.sel   = '0;
    s.adr   = '0;
    s.dat_w = '0;
    case (owner_q)
      OWN_M0: begin
        s.cyc   = m0.cyc;
        s.stb   = m0.stb;
        s.we    = m0.we;
        s.sel   = m0.sel;
        s.adr   = m0.adr;
        s.dat_w = m0.dat_w;
      end
      OWN_M1: begin
        s.cyc   = m1.cyc;
        s.stb   = m1.stb;
        s.we    = m1.we;
        s.sel   = m1.sel;
        s.adr   = m1.adr;
        s.dat_w = m1.dat_w;
      end
      default: ;
    endcase
  end

  // Return path, a waiting master sees no response
  assign m0.ack   = m0.bus_gnt & s.ack;
  assign m0.err   = m0.bus_gnt & s.err;
  assign m0.dat_r = m0.bus_gnt ? s.dat_r : '0;
  assign m1.ack   = m1.bus_gnt & s.ack;
  assign m1.err   = m1.bus_gnt & s.err;
  assign m1.dat_r = m1.bus_gnt ? s.dat_r : '0;

  // A slave response never arrives after its owner has been released
  a_resp_owned: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (s.ack || s.err) |-> (m0.bus_gnt || m1.bus_gnt));

endmodule

// ==== src/wb_sram.sv ====
module wb_sram (
  input  logic clk_i,
  input  logic rst_n_i,
  wb_if.slave  bus
);
  import rv32_mem_pkg::*;

  logic [XLEN-1:0] mem [SRAM_WORDS];

  logic               in_range;
  logic               new_req;
  logic [SRAM_AW-1:0] idx;

  assign in_range = (bus.adr < WB_ADR_W'(SRAM_WORDS));
  assign idx      = bus.adr[SRAM_AW-1:0];
  // One response per strobe, skip the cycle right after a response
  assign new_req  = bus.cyc && bus.stb && !bus.ack && !bus.err;

  // Response flags
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      bus.ack <= 1'b0;
      bus.err <= 1'b0;
    end else begin
      bus.ack <= new_req && in_range;
      bus.err <= new_req && !in_range;
    end
  end

  // Storage and read word
  always_ff @(posedge clk_i) begin
    if (new_req && in_range) begin
      // Master picks its lane out of the full word
      bus.dat_r <= mem[idx];
      if (bus.we) begin
        for (int i = 0; i < SEL_W; i++) begin
          if (bus.sel[i]) begin
            mem[idx][i*8 +: 8] <= bus.dat_w[i*8 +: 8];
          end
        end
      end
    end
  end

  a_ack_err_excl: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(bus.ack && bus.err));

endmodule

// ==== src/mem_subsys_top.sv ====
module mem_subsys_top (
  input  logic                              clk_i,
  input  logic                              rst_n_i,
  // Core request channel
  input  logic                              req_i,
  input  logic                              we_i,
  input  logic                              unsigned_i,
  input  rv32_mem_pkg::mem_size_t           size_i,
  input  logic [rv32_mem_pkg::XLEN-1:0]     addr_i,
  input  logic [rv32_mem_pkg::XLEN-1:0]     wdata_i,
  output logic                              ack_o,
  output logic                              err_o,
  output logic [rv32_mem_pkg::XLEN-1:0]     rdata_o,
  // DMA Wishbone port
  input  logic                              dma_cyc_i,
  input  logic                              dma_we_i,
  input  logic [rv32_mem_pkg::SEL_W-1:0]    dma_sel_i,
  input  logic [rv32_mem_pkg::WB_ADR_W-1:0] dma_adr_i,
  input  logic [rv32_mem_pkg::XLEN-1:0]     dma_dat_i,
  output logic [rv32_mem_pkg::XLEN-1:0]     dma_dat_o,
  output logic                              dma_ack_o,
  output logic                              dma_err_o
);

  wb_if lsu_bus ();
  wb_if dma_bus ();
  wb_if mem_bus ();

  // DMA cyc doubles as strobe and as its arbiter request
  assign dma_bus.cyc     = dma_cyc_i;
  assign dma_bus.stb     = dma_cyc_i;
  assign dma_bus.bus_req = dma_cyc_i;
  assign dma_bus.we      = dma_we_i;
  assign dma_bus.sel     = dma_sel_i;
  assign dma_bus.adr     = dma_adr_i;
  assign dma_bus.dat_w   = dma_dat_i;
  assign dma_dat_o       = dma_bus.dat_r;
  assign dma_ack_o       = dma_bus.ack;
  assign dma_err_o       = dma_bus.err;

  lsu_wb_master u_lsu (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .req_i      (req_i),
    .we_i       (we_i),
    .unsigned_i (unsigned_i),
    .size_i     (size_i),
    .addr_i     (addr_i),
    .wdata_i    (wdata_i),
    .ack_o      (ack_o),
    .err_o      (err_o),
    .rdata_o    (rdata_o),
    .bus        (lsu_bus)
  );

  // LSU wins ties on m0
  wb_arbiter u_arb (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .m0      (lsu_bus),
    .m1      (dma_bus),
    .s       (mem_bus)
  );

  wb_sram u_sram (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .bus     (mem_bus)
  );

endmodule

// ==== tb/tb_mem_subsys.sv ====
module tb_mem_subsys;
  timeunit 1ns;
  timeprecision 100ps;
  import rv32_mem_pkg::*;

  // About 80 accesses at under 40 cycles each, plus reset, with margin
  localparam int MAX_CYCLES = 4000;
  // Longest wait for one handshake edge, covers a DMA cycle ahead of the core
  localparam int HS_LIMIT = 40;

  logic clk_i = 1'b0;
  logic rst_n_i;
  logic req_i, we_i, unsigned_i;
  mem_size_t size_i;
  logic [XLEN-1:0] addr_i, wdata_i, rdata_o;
  logic ack_o, err_o;
  logic dma_cyc_i, dma_we_i;
  logic [SEL_W-1:0] dma_sel_i;
  logic [WB_ADR_W-1:0] dma_adr_i;
  logic [XLEN-1:0] dma_dat_i, dma_dat_o;
  logic dma_ack_o, dma_err_o;

  // Reference copy of the SRAM contents
  logic [XLEN-1:0] ref_mem [SRAM_WORDS];
  logic [15:0] lfsr_q = 16'd81;
  int errors = 0;
  int test_err_start = 0;
  int pass_count = 0;
  int fail_count = 0;
  int cycles = 0;

  mem_subsys_top DUT (.*);

  always #10 clk_i = ~clk_i;

  // Run limit
  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout after %0d cycles", cycles);
      $display("SOME TESTS FAILED");
      $finish;
    end
  end

  // Taps 16,14,13,11, one step per bit
  function automatic logic [31:0] rand_bits(int n);
    logic [31:0] r;
    logic fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
      lfsr_q = {lfsr_q[14:0], fb};
      r = {r[30:0], fb};
    end
    return r;
  endfunction

  function automatic logic is_bad_align(mem_size_t size, logic [1:0] off);
    if (size == MEM_HALF) return off[0];
    if (size == MEM_WORD) return off != 2'b00;
    return 1'b0;
  endfunction

  // Pick the addressed byte or half, then extend it
  function automatic logic [XLEN-1:0] expected_load(logic [XLEN-1:0] word, logic [1:0] off,
                                                    mem_size_t size, logic uns);
    logic [7:0]  b;
    logic [15:0] h;
    b = word[8*off +: 8];
    h = off[1] ? word[31:16] : word[15:0];
    case (size)
      MEM_BYTE: return uns ? {24'h0, b} : {{24{b[7]}}, b};
      MEM_HALF: return uns ? {16'h0, h} : {{16{h[15]}}, h};
      default:  return word;
    endcase
  endfunction

  function automatic void apply_store(logic [XLEN-1:0] addr, logic [XLEN-1:0] data,
                                      mem_size_t size);
    logic [SRAM_AW-1:0] w;
    w = addr[SRAM_AW+1:2];
    case (size)
      MEM_BYTE: ref_mem[w][8*addr[1:0] +: 8] = data[7:0];
      MEM_HALF: ref_mem[w][16*addr[1] +: 16] = data[15:0];
      default:  ref_mem[w] = data;
    endcase
  endfunction

  task automatic check_word(string name, logic [XLEN-1:0] got, logic [XLEN-1:0] exp);
    if (got !== exp) begin
      $display("Mismatch %s: got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_flag(string name, logic got, logic exp);
    if (got !== exp) begin
      $display("Mismatch %s: got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  // Full four-phase core handshake, starts and ends on a falling edge
  task automatic core_access(input logic we, input logic uns, input mem_size_t size,
                             input logic [XLEN-1:0] addr, input logic [XLEN-1:0] wdata,
                             output logic [XLEN-1:0] rdata, output logic err);
    int n;
    req_i      = 1'b1;
    we_i       = we;
    unsigned_i = uns;
    size_i     = size;
    addr_i     = addr;
    wdata_i    = wdata;
    n = 0;
    @(negedge clk_i);
    while (!ack_o && n < HS_LIMIT) begin
      @(negedge clk_i);
      n++;
    end
    if (!ack_o) begin
      $display("Core access at %h got no acknowledge", addr);
      errors++;
    end
    rdata = rdata_o;
    err   = err_o;
    req_i = 1'b0;
    we_i  = 1'b0;
    n = 0;
    @(negedge clk_i);
    while (ack_o && n < HS_LIMIT) begin
      @(negedge clk_i);
      n++;
    end
    if (ack_o) begin
      $display("Core acknowledge stayed high after the request dropped");
      errors++;
    end
  endtask

  // One DMA cycle, then one idle cycle so the arbiter can release the bus
  task automatic dma_access(input logic we, input logic [SEL_W-1:0] sel,
                            input logic [WB_ADR_W-1:0] adr, input logic [XLEN-1:0] dat,
                            output logic [XLEN-1:0] rdata, output logic err);
    int n;
    dma_cyc_i = 1'b1;
    dma_we_i  = we;
    dma_sel_i = sel;
    dma_adr_i = adr;
    dma_dat_i = dat;
    n = 0;
    @(negedge clk_i);
    while (!dma_ack_o && !dma_err_o && n < HS_LIMIT) begin
      @(negedge clk_i);
      n++;
    end
    if (!dma_ack_o && !dma_err_o) begin
      $display("DMA cycle at word %h got no response", adr);
      errors++;
    end
    rdata     = dma_dat_o;
    err       = dma_err_o;
    dma_cyc_i = 1'b0;
    dma_we_i  = 1'b0;
    @(negedge clk_i);
  endtask

  task automatic report_result(string name);
    if (errors == test_err_start) begin
      pass_count++;
      $display("PASS %s", name);
    end else begin
      fail_count++;
      $display("FAIL %s (%0d errors)", name, errors - test_err_start);
    end
    test_err_start = errors;
  endtask

  task automatic reset_state();
    check_flag("ack_o", ack_o, 1'b0);
    check_flag("err_o", err_o, 1'b0);
    check_flag("dma_ack_o", dma_ack_o, 1'b0);
    check_flag("dma_err_o", dma_err_o, 1'b0);
    report_result("reset state");
  endtask

  task automatic word_store_load();
    logic [XLEN-1:0] a [16];
    logic [XLEN-1:0] d, rd;
    logic er;
    for (int i = 0; i < 16; i++) begin
      a[i] = XLEN'(rand_bits(SRAM_AW)) << 2;
      d = rand_bits(XLEN);
      core_access(1'b1, 1'b0, MEM_WORD, a[i], d, rd, er);
      check_flag("err_o", er, 1'b0);
      apply_store(a[i], d, MEM_WORD);
    end
    for (int i = 0; i < 16; i++) begin
      core_access(1'b0, 1'b0, MEM_WORD, a[i], '0, rd, er);
      check_flag("err_o", er, 1'b0);
      check_word("rdata_o", rd, ref_mem[a[i][SRAM_AW+1:2]]);
    end
    report_result("word store and load");
  endtask

  task automatic lane_access();
    logic [XLEN-1:0] base, d, rd;
    logic er;
    base = XLEN'(300) << 2;
    d = rand_bits(XLEN);
    core_access(1'b1, 1'b0, MEM_WORD, base, d, rd, er);
    apply_store(base, d, MEM_WORD);
    // Bytes at each offset, halves on both half boundaries
    for (int off = 0; off < 4; off++) begin
      d = rand_bits(8);
      core_access(1'b1, 1'b0, MEM_BYTE, base + off, d, rd, er);
      check_flag("err_o", er, 1'b0);
      apply_store(base + off, d, MEM_BYTE);
    end
    // Halves below overwrite every byte, so the merged bytes are read here
    core_access(1'b0, 1'b0, MEM_WORD, base, '0, rd, er);
    check_word("rdata_o", rd, ref_mem[300]);
    for (int off = 0; off < 4; off += 2) begin
      d = rand_bits(16);
      // Mixed sign bits so signed and unsigned loads differ on some lanes
      if (off == 0) begin
        d = (d | 32'h0080) & 32'h7fff;
      end else begin
        d = (d & 32'hff7f) | 32'h8000;
      end
      core_access(1'b1, 1'b0, MEM_HALF, base + off, d, rd, er);
      check_flag("err_o", er, 1'b0);
      apply_store(base + off, d, MEM_HALF);
    end
    for (int off = 0; off < 4; off++) begin
      for (int u = 0; u < 2; u++) begin
        core_access(1'b0, u[0], MEM_BYTE, base + off, '0, rd, er);
        check_word("rdata_o", rd, expected_load(ref_mem[300], off[1:0], MEM_BYTE, u[0]));
        if (!off[0]) begin
          core_access(1'b0, u[0], MEM_HALF, base + off, '0, rd, er);
          check_word("rdata_o", rd, expected_load(ref_mem[300], off[1:0], MEM_HALF, u[0]));
        end
      end
    end
    core_access(1'b0, 1'b0, MEM_WORD, base, '0, rd, er);
    check_word("rdata_o", rd, ref_mem[300]);
    report_result("byte and halfword lanes");
  endtask

  task automatic misaligned_access();
    logic [XLEN-1:0] base, rd;
    logic er;
    base = XLEN'(400) << 2;
    core_access(1'b1, 1'b0, MEM_WORD, base, 32'h1357_9bdf, rd, er);
    apply_store(base, 32'h1357_9bdf, MEM_WORD);
    for (int off = 1; off < 4; off++) begin
      if (is_bad_align(MEM_HALF, off[1:0])) begin
        core_access(1'b1, 1'b0, MEM_HALF, base + off, 32'hffff_ffff, rd, er);
        check_flag("err_o", er, 1'b1);
      end
      core_access(1'b1, 1'b0, MEM_WORD, base + off, 32'hffff_ffff, rd, er);
      check_flag("err_o", er, is_bad_align(MEM_WORD, off[1:0]));
    end
    core_access(1'b0, 1'b0, MEM_WORD, base, '0, rd, er);
    check_flag("err_o", er, 1'b0);
    check_word("rdata_o", rd, ref_mem[400]);
    report_result("misaligned access");
  endtask

  task automatic out_of_range();
    logic [XLEN-1:0] rd;
    logic er;
    int words [3] = '{0, 5, SRAM_WORDS - 1};
    foreach (words[i]) begin
      core_access(1'b1, 1'b0, MEM_WORD, XLEN'(words[i]) << 2, rand_bits(XLEN), rd, er);
      apply_store(XLEN'(words[i]) << 2, wdata_i, MEM_WORD);
    end
    // Low address bits alias onto words 0, 5 and the last word
    core_access(1'b1, 1'b0, MEM_WORD, XLEN'(SRAM_WORDS) << 2, 32'hdead_beef, rd, er);
    check_flag("err_o", er, 1'b1);
    core_access(1'b0, 1'b0, MEM_WORD, 32'hffff_fffc, '0, rd, er);
    check_flag("err_o", er, 1'b1);
    dma_access(1'b1, 4'hf, WB_ADR_W'(SRAM_WORDS + 5), 32'hbad0_cafe, rd, er);
    check_flag("dma_err_o", er, 1'b1);
    foreach (words[i]) begin
      core_access(1'b0, 1'b0, MEM_WORD, XLEN'(words[i]) << 2, '0, rd, er);
      check_word("rdata_o", rd, ref_mem[words[i]]);
    end
    report_result("out-of-range address");
  endtask

  task automatic shared_bus();
    logic [XLEN-1:0] cd, dd, rd_c, rd_d;
    logic er_c, er_d;
    cd = rand_bits(XLEN);
    dd = rand_bits(XLEN);
    fork
      core_access(1'b1, 1'b0, MEM_WORD, XLEN'(100) << 2, cd, rd_c, er_c);
      dma_access(1'b1, 4'hf, WB_ADR_W'(200), dd, rd_d, er_d);
    join
    check_flag("err_o", er_c, 1'b0);
    check_flag("dma_err_o", er_d, 1'b0);
    // Each master reads what the other one wrote
    core_access(1'b0, 1'b0, MEM_WORD, XLEN'(200) << 2, '0, rd_c, er_c);
    check_word("rdata_o", rd_c, dd);
    dma_access(1'b0, 4'hf, WB_ADR_W'(100), '0, rd_d, er_d);
    check_word("dma_dat_o", rd_d, cd);
    report_result("shared bus");
  endtask

  initial begin
    rst_n_i    = 1'b0;
    req_i      = 1'b0;
    we_i       = 1'b0;
    unsigned_i = 1'b0;
    size_i     = MEM_WORD;
    addr_i     = '0;
    wdata_i    = '0;
    dma_cyc_i  = 1'b0;
    dma_we_i   = 1'b0;
    dma_sel_i  = '0;
    dma_adr_i  = '0;
    dma_dat_i  = '0;
    repeat (5) @(posedge clk_i);
    @(negedge clk_i);
    rst_n_i = 1'b1;
    @(negedge clk_i);

    reset_state();
    word_store_load();
    lane_access();
    misaligned_access();
    out_of_range();
    shared_bus();

    $display("Tests passed: %0d, failed: %0d", pass_count, fail_count);
    if (fail_count == 0 && errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

// ==== rv32_mem.f ====
src/rv32_mem_pkg.sv
src/wb_if.sv
src/lsu_wb_master.sv
src/wb_arbiter.sv
src/wb_sram.sv
src/mem_subsys_top.sv
tb/tb_mem_subsys.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the memory subsystem testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_mem_subsys \
  --Mdir obj_dir -o sim_tb \
  -f rv32_mem.f

./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "SOME TESTS FAILED" sim.log; then
  echo "Simulation reported failures, see sim.log"
  exit 1
fi

echo "Simulation finished, log in sim.log"
exit 0
